// File: source/ex_pkg.sv
`default_nettype none

package ex_pkg;

  //////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////

  // Integer datapath width, also sets the product width
  localparam int unsigned WORD_WIDTH = 32;

  // Integer register file only, 32 entries
  localparam int unsigned REG_ADDR_WIDTH = 5;

  //////////////////////////////////////////////////
  // Vector types
  //////////////////////////////////////////////////

  // Operands, results, CSR and load data
  typedef logic [WORD_WIDTH-1:0] word_t;

  typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;

  //////////////////////////////////////////////////
  // Operator encodings
  //////////////////////////////////////////////////

  // ALU operators, branch comparisons in the upper half
  typedef enum logic [3:0] {
    ADD  = 4'd0,
    SUB  = 4'd1,
    AND  = 4'd2,
    OR   = 4'd3,
    XOR  = 4'd4,
    SLL  = 4'd5,
    SRL  = 4'd6,
    SRA  = 4'd7,
    SLT  = 4'd8,
    SLTU = 4'd9,
    EQ   = 4'd10,
    NE   = 4'd11,
    LT   = 4'd12,
    GE   = 4'd13,
    LTU  = 4'd14,
    GEU  = 4'd15
  } alu_op_e;

  // MUL gives the low word, the rest the high word
  typedef enum logic [1:0] {
    MUL    = 2'd0,
    MULH   = 2'd1,
    MULHSU = 2'd2,
    MULHU  = 2'd3
  } mult_op_e;

endpackage

`default_nettype wire

// File: source/ex_result_if.sv
`timescale 1ns/10ps
`default_nettype none

// Unit results toward the write-back logic
// Plain levels, sampled while the stage is ready
interface ex_result_if;

  ex_pkg::word_t alu_result;
  logic          cmp_result;
  ex_pkg::word_t mult_result;
  logic          mult_ready;

  // ALU side
  modport alu (
    output alu_result,
    output cmp_result
  );

  // Multiplier side, ready low while the high word is pending
  modport mult (
    output mult_result,
    output mult_ready
  );

  // Write-back and stall control
  modport wb (
    input alu_result,
    input cmp_result,
    input mult_result,
    input mult_ready
  );

endinterface

`default_nettype wire

// File: source/ex_alu.sv
`timescale 1ns/10ps
`default_nettype none

module ex_alu (
  input  ex_pkg::alu_op_e operator_i,
  input  ex_pkg::word_t   operand_a_i,
  input  ex_pkg::word_t   operand_b_i,
  ex_result_if.alu        res
);

  localparam int unsigned W = ex_pkg::WORD_WIDTH;

  logic                   sub_sel;
  ex_pkg::word_t          adder_b;
  ex_pkg::word_t          adder_res;
  logic [$clog2(W)-1:0]   shamt;
  logic                   shift_left;
  logic                   shift_arith;
  ex_pkg::word_t          shift_in;
  logic [W:0]             shift_ext;
  logic [W:0]             shift_out;
  ex_pkg::word_t          shift_res;
  logic                   cmp_signed;
  logic                   less;
  logic                   equal;

  // Mirror a word, lets one right shifter do left shifts too
  function automatic ex_pkg::word_t bit_reverse(input ex_pkg::word_t value);
    ex_pkg::word_t rev;
    for (int i = 0; i < W; i++) begin
      rev[i] = value[W-1-i];
    end
    return rev;
  endfunction

  //////////////////////////////////////////////////
  // Adder
  //////////////////////////////////////////////////

  // Subtract as a + ~b + 1
  assign sub_sel   = (operator_i == ex_pkg::SUB);
  assign adder_b   = sub_sel ? ~operand_b_i : operand_b_i;
  assign adder_res = operand_a_i + adder_b + ex_pkg::word_t'(sub_sel);

  //////////////////////////////////////////////////
  // Shifter
  //////////////////////////////////////////////////

  // Shift amount from the low bits of b only
  assign shamt       = operand_b_i[$clog2(W)-1:0];
  assign shift_left  = (operator_i == ex_pkg::SLL);
  assign shift_arith = (operator_i == ex_pkg::SRA);
  assign shift_in    = shift_left ? bit_reverse(operand_a_i) : operand_a_i;

  // Extra top bit carries the sign for SRA, zero otherwise
  assign shift_ext = {shift_arith & operand_a_i[W-1], shift_in};
  assign shift_out = $signed(shift_ext) >>> shamt;
  assign shift_res = shift_left ? bit_reverse(shift_out[W-1:0]) : shift_out[W-1:0];

  //////////////////////////////////////////////////
  // Comparator
  //////////////////////////////////////////////////

  assign cmp_signed = operator_i inside {ex_pkg::SLT, ex_pkg::LT, ex_pkg::GE};

  // Sign or zero extend to one common signed compare
  assign less  = $signed({cmp_signed & operand_a_i[W-1], operand_a_i})
               < $signed({cmp_signed & operand_b_i[W-1], operand_b_i});
  assign equal = (operand_a_i == operand_b_i);

  // Branch decision
  always_comb begin
    case (operator_i)
      ex_pkg::EQ:                                        res.cmp_result = equal;
      ex_pkg::NE:                                        res.cmp_result = ~equal;
      ex_pkg::LT, ex_pkg::LTU, ex_pkg::SLT, ex_pkg::SLTU: res.cmp_result = less;
      ex_pkg::GE, ex_pkg::GEU:                           res.cmp_result = ~less;
      default:                                           res.cmp_result = 1'b0;
    endcase
  end

  // Result select, branch-only operators give zero
  always_comb begin
    case (operator_i)
      ex_pkg::ADD, ex_pkg::SUB:               res.alu_result = adder_res;
      ex_pkg::AND:                            res.alu_result = operand_a_i & operand_b_i;
      ex_pkg::OR:                             res.alu_result = operand_a_i | operand_b_i;
      ex_pkg::XOR:                            res.alu_result = operand_a_i ^ operand_b_i;
      ex_pkg::SLL, ex_pkg::SRL, ex_pkg::SRA:  res.alu_result = shift_res;
      ex_pkg::SLT, ex_pkg::SLTU:              res.alu_result = ex_pkg::word_t'(less);
      default:                                res.alu_result = '0;
    endcase
  end

  // Known operator and operands must give a known result
  alu_result_known_a: assert final (
    $isunknown({operator_i, operand_a_i, operand_b_i}) || !$isunknown(res.alu_result)
  ) else $error("ALU result unknown for operator %0d", operator_i);

endmodule

`default_nettype wire

// File: source/ex_mult.sv
`timescale 1ns/10ps
`default_nettype none

module ex_mult #(
  parameter bit SPLIT_HIGH = 1'b1
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             enable_i,
  input  ex_pkg::mult_op_e operator_i,
  input  ex_pkg::word_t    op_a_i,
  input  ex_pkg::word_t    op_b_i,
  input  logic             ex_ready_i,
  output logic             multicycle_o,
  ex_result_if.mult        res
);

  localparam int unsigned W = ex_pkg::WORD_WIDTH;

  typedef enum logic {
    MULT_IDLE,
    MULT_FINISH
  } mult_state_e;

  mult_state_e         state_q;
  mult_state_e         state_d;
  logic                signed_a;
  logic                signed_b;
  logic signed [W:0]   op_a_ext;
  logic signed [W:0]   op_b_ext;
  logic signed [2*W+1:0] prod_full;
  logic [2*W-1:0]      product;
  logic                high_op;
  logic                split_start;
  ex_pkg::word_t       prod_hi_q;

  //////////////////////////////////////////////////
  // Product
  //////////////////////////////////////////////////

  // MULH signs both, MULHSU only a, MULHU none
  assign signed_a = operator_i inside {ex_pkg::MULH, ex_pkg::MULHSU};
  assign signed_b = (operator_i == ex_pkg::MULH);
  assign high_op  = (operator_i != ex_pkg::MUL);

  assign op_a_ext = {signed_a & op_a_i[W-1], op_a_i};
  assign op_b_ext = {signed_b & op_b_i[W-1], op_b_i};

  // 33x33 signed multiply, the low 64 bits are the product
  assign prod_full = op_a_ext * op_b_ext;
  assign product   = prod_full[2*W-1:0];

  //////////////////////////////////////////////////
  // High word FSM
  //////////////////////////////////////////////////

  // A high product entering from idle takes an extra cycle
  assign split_start = SPLIT_HIGH && enable_i && high_op && (state_q == MULT_IDLE);

  always_comb begin
    state_d = state_q;
    case (state_q)
      MULT_IDLE: begin
        if (split_start) begin
          state_d = MULT_FINISH;
        end
      end
      // Hold the result until the stage moves on
      MULT_FINISH: begin
        if (ex_ready_i) begin
          state_d = MULT_IDLE;
        end
      end
      default: state_d = MULT_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= MULT_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // High word register, released in the finish state
  always_ff @(posedge clk) begin
    if (split_start) begin
      prod_hi_q <= product[2*W-1:W];
    end
  end

  //////////////////////////////////////////////////
  // Outputs
  //////////////////////////////////////////////////

  assign multicycle_o   = split_start;
  assign res.mult_ready = ~split_start;

  always_comb begin
    if (state_q == MULT_FINISH) begin
      res.mult_result = prod_hi_q;
    end else if (high_op) begin
      res.mult_result = product[2*W-1:W];
    end else begin
      res.mult_result = product[W-1:0];
    end
  end

  // The multiplier stalls only for an issued operation
  mult_ready_needs_en_a: assert property (
    @(posedge clk) disable iff (!rst_n) !res.mult_ready |-> enable_i
  ) else $error("mult_ready low with no multiply issued");

  // The low product never needs a second cycle
  mul_single_cycle_a: assert property (
    @(posedge clk) disable iff (!rst_n) multicycle_o |-> (operator_i != ex_pkg::MUL)
  ) else $error("multicycle raised for MUL");

endmodule

`default_nettype wire

// File: source/ex_wb_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module ex_wb_ctrl (
  input  logic              clk,
  input  logic              rst_n,
  ex_result_if.wb           res,
  input  logic              alu_en_i,
  input  logic              mult_en_i,
  input  logic              csr_access_i,
  input  ex_pkg::word_t     csr_rdata_i,
  input  logic              lsu_en_i,
  input  ex_pkg::word_t     lsu_rdata_i,
  input  logic              lsu_ready_ex_i,
  input  logic              lsu_err_i,
  input  logic              branch_in_ex_i,
  input  logic              regfile_alu_we_i,
  input  ex_pkg::reg_addr_t regfile_alu_waddr_i,
  input  logic              regfile_we_i,
  input  ex_pkg::reg_addr_t regfile_waddr_i,
  input  logic              wb_ready_i,
  output logic              regfile_alu_we_fw_o,
  output ex_pkg::reg_addr_t regfile_alu_waddr_fw_o,
  output ex_pkg::word_t     regfile_alu_wdata_fw_o,
  output logic              regfile_we_wb_o,
  output ex_pkg::reg_addr_t regfile_waddr_wb_o,
  output ex_pkg::word_t     regfile_wdata_wb_o,
  output logic              ex_ready_o,
  output logic              ex_valid_o
);

  logic              units_ready;
  logic              any_en;
  logic              we_capture;
  logic              we_lsu_q;
  ex_pkg::reg_addr_t waddr_lsu_q;

  //////////////////////////////////////////////////
  // ALU write port
  //////////////////////////////////////////////////

  assign regfile_alu_we_fw_o    = regfile_alu_we_i;
  assign regfile_alu_waddr_fw_o = regfile_alu_waddr_i;

  // CSR over multiplier over ALU, zero when idle
  always_comb begin
    if (csr_access_i) begin
      regfile_alu_wdata_fw_o = csr_rdata_i;
    end else if (mult_en_i) begin
      regfile_alu_wdata_fw_o = res.mult_result;
    end else if (alu_en_i) begin
      regfile_alu_wdata_fw_o = res.alu_result;
    end else begin
      regfile_alu_wdata_fw_o = '0;
    end
  end

  //////////////////////////////////////////////////
  // EX/WB register for the load port
  //////////////////////////////////////////////////

  // A faulting load never writes back
  assign we_capture = regfile_we_i & ~lsu_err_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      we_lsu_q <= 1'b0;
    end else if (ex_valid_o) begin
      we_lsu_q <= we_capture;
    end else if (wb_ready_i) begin
      // WB drained and nothing new, drop the entry
      we_lsu_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (ex_valid_o && we_capture) begin
      waddr_lsu_q <= regfile_waddr_i;
    end
  end

  assign regfile_we_wb_o    = we_lsu_q;
  assign regfile_waddr_wb_o = waddr_lsu_q;
  // Load data arrives in the WB cycle itself
  assign regfile_wdata_wb_o = lsu_rdata_i;

  //////////////////////////////////////////////////
  // Stall control
  //////////////////////////////////////////////////

  assign units_ready = res.mult_ready & lsu_ready_ex_i & wb_ready_i;
  assign any_en      = alu_en_i | mult_en_i | csr_access_i | lsu_en_i;

  // Branches resolve in EX, so they never wait on WB
  assign ex_ready_o = units_ready | branch_in_ex_i;
  assign ex_valid_o = any_en & units_ready;

  // Decode issues to one forward source at a time
  one_source_a: assert property (
    @(posedge clk) disable iff (!rst_n) $onehot0({alu_en_i, mult_en_i, csr_access_i})
  ) else $error("More than one forward source enabled");

  no_wb_after_err_a: assert property (
    @(posedge clk) disable iff (!rst_n) (ex_valid_o && lsu_err_i) |=> !regfile_we_wb_o
  ) else $error("Write-back enabled after a load error");

endmodule

`default_nettype wire

// File: source/ex_stage.sv
`timescale 1ns/10ps
`default_nettype none

module ex_stage #(
  parameter bit MULT_SPLIT_HIGH = 1'b1
) (
  input  logic              clk,
  input  logic              rst_n,

  // ALU
  input  logic              alu_en_i,
  input  ex_pkg::alu_op_e   alu_operator_i,
  input  ex_pkg::word_t     alu_operand_a_i,
  input  ex_pkg::word_t     alu_operand_b_i,
  input  ex_pkg::word_t     alu_operand_c_i,

  // Multiplier
  input  logic              mult_en_i,
  input  ex_pkg::mult_op_e  mult_operator_i,
  input  ex_pkg::word_t     mult_operand_a_i,
  input  ex_pkg::word_t     mult_operand_b_i,

  // CSR and load unit
  input  logic              csr_access_i,
  input  ex_pkg::word_t     csr_rdata_i,
  input  logic              lsu_en_i,
  input  ex_pkg::word_t     lsu_rdata_i,
  input  logic              lsu_ready_ex_i,
  input  logic              lsu_err_i,

  // From ID
  input  logic              branch_in_ex_i,
  input  logic              regfile_alu_we_i,
  input  ex_pkg::reg_addr_t regfile_alu_waddr_i,
  input  logic              regfile_we_i,
  input  ex_pkg::reg_addr_t regfile_waddr_i,
  input  logic              wb_ready_i,

  output logic              mult_multicycle_o,
  output logic              regfile_alu_we_fw_o,
  output ex_pkg::reg_addr_t regfile_alu_waddr_fw_o,
  output ex_pkg::word_t     regfile_alu_wdata_fw_o,
  output logic              regfile_we_wb_o,
  output ex_pkg::reg_addr_t regfile_waddr_wb_o,
  output ex_pkg::word_t     regfile_wdata_wb_o,
  output logic              branch_decision_o,
  output ex_pkg::word_t     jump_target_o,
  output logic              ex_ready_o,
  output logic              ex_valid_o
);

  ex_result_if result_if ();

  // Branch outcome from the ALU comparator, target computed in ID
  assign branch_decision_o = result_if.cmp_result;
  assign jump_target_o     = alu_operand_c_i;

  ex_alu alu_i (
    .operator_i  (alu_operator_i),
    .operand_a_i (alu_operand_a_i),
    .operand_b_i (alu_operand_b_i),
    .res         (result_if.alu)
  );

  ex_mult #(
    .SPLIT_HIGH (MULT_SPLIT_HIGH)
  ) mult_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .enable_i     (mult_en_i),
    .operator_i   (mult_operator_i),
    .op_a_i       (mult_operand_a_i),
    .op_b_i       (mult_operand_b_i),
    .ex_ready_i   (ex_ready_o),
    .multicycle_o (mult_multicycle_o),
    .res          (result_if.mult)
  );

  ex_wb_ctrl wb_ctrl_i (
    .clk                    (clk),
    .rst_n                  (rst_n),
    .res                    (result_if.wb),
    .alu_en_i               (alu_en_i),
    .mult_en_i              (mult_en_i),
    .csr_access_i           (csr_access_i),
    .csr_rdata_i            (csr_rdata_i),
    .lsu_en_i               (lsu_en_i),
    .lsu_rdata_i            (lsu_rdata_i),
    .lsu_ready_ex_i         (lsu_ready_ex_i),
    .lsu_err_i              (lsu_err_i),
    .branch_in_ex_i         (branch_in_ex_i),
    .regfile_alu_we_i       (regfile_alu_we_i),
    .regfile_alu_waddr_i    (regfile_alu_waddr_i),
    .regfile_we_i           (regfile_we_i),
    .regfile_waddr_i        (regfile_waddr_i),
    .wb_ready_i             (wb_ready_i),
    .regfile_alu_we_fw_o    (regfile_alu_we_fw_o),
    .regfile_alu_waddr_fw_o (regfile_alu_waddr_fw_o),
    .regfile_alu_wdata_fw_o (regfile_alu_wdata_fw_o),
    .regfile_we_wb_o        (regfile_we_wb_o),
    .regfile_waddr_wb_o     (regfile_waddr_wb_o),
    .regfile_wdata_wb_o     (regfile_wdata_wb_o),
    .ex_ready_o             (ex_ready_o),
    .ex_valid_o             (ex_valid_o)
  );

endmodule

`default_nettype wire

// File: bench/tb_ex_stage.sv
`timescale 1ns/10ps
`default_nettype none

module tb_ex_stage;

  localparam time         CLK_PERIOD    = 100ns;
  localparam time         DRIVE_DELAY   = 10ns;
  localparam int unsigned READY_TIMEOUT = 50;
  localparam int unsigned NUM_OPS       = 400;
  localparam bit [31:0]   SEED          = 32'hc0be;

  logic              clk;
  logic              rst_n;
  logic              alu_en_i;
  ex_pkg::alu_op_e   alu_operator_i;
  ex_pkg::word_t     alu_operand_a_i;
  ex_pkg::word_t     alu_operand_b_i;
  ex_pkg::word_t     alu_operand_c_i;
  logic              mult_en_i;
  ex_pkg::mult_op_e  mult_operator_i;
  ex_pkg::word_t     mult_operand_a_i;
  ex_pkg::word_t     mult_operand_b_i;
  logic              csr_access_i;
  ex_pkg::word_t     csr_rdata_i;
  logic              lsu_en_i;
  ex_pkg::word_t     lsu_rdata_i;
  logic              lsu_ready_ex_i;
  logic              lsu_err_i;
  logic              branch_in_ex_i;
  logic              regfile_alu_we_i;
  ex_pkg::reg_addr_t regfile_alu_waddr_i;
  logic              regfile_we_i;
  ex_pkg::reg_addr_t regfile_waddr_i;
  logic              wb_ready_i;
  logic              mult_multicycle_o;
  logic              regfile_alu_we_fw_o;
  ex_pkg::reg_addr_t regfile_alu_waddr_fw_o;
  ex_pkg::word_t     regfile_alu_wdata_fw_o;
  logic              regfile_we_wb_o;
  ex_pkg::reg_addr_t regfile_waddr_wb_o;
  ex_pkg::word_t     regfile_wdata_wb_o;
  logic              branch_decision_o;
  ex_pkg::word_t     jump_target_o;
  logic              ex_ready_o;
  logic              ex_valid_o;

  int unsigned mismatch_count;
  int unsigned timeout_count;
  bit          timed_out;

  ex_stage #(
    .MULT_SPLIT_HIGH (1'b1)
  ) dut_i (.*);

  // Free running clock
  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  function automatic ex_pkg::word_t alu_model(input ex_pkg::alu_op_e op,
                                              input ex_pkg::word_t a, input ex_pkg::word_t b);
    case (op)
      ex_pkg::ADD:  return a + b;
      ex_pkg::SUB:  return a - b;
      ex_pkg::AND:  return a & b;
      ex_pkg::OR:   return a | b;
      ex_pkg::XOR:  return a ^ b;
      ex_pkg::SLL:  return a << b[4:0];
      ex_pkg::SRL:  return a >> b[4:0];
      ex_pkg::SRA:  return ex_pkg::word_t'($signed(a) >>> b[4:0]);
      ex_pkg::SLT:  return {31'b0, $signed(a) < $signed(b)};
      ex_pkg::SLTU: return {31'b0, a < b};
      default:      return '0;
    endcase
  endfunction

  // Branch outcome per RISC-V compare
  function automatic logic cmp_model(input ex_pkg::alu_op_e op,
                                     input ex_pkg::word_t a, input ex_pkg::word_t b);
    case (op)
      ex_pkg::EQ:  return a == b;
      ex_pkg::NE:  return a != b;
      ex_pkg::LT:  return $signed(a) < $signed(b);
      ex_pkg::GE:  return $signed(a) >= $signed(b);
      ex_pkg::LTU: return a < b;
      ex_pkg::GEU: return a >= b;
      default:     return 1'b0;
    endcase
  endfunction

  // Extend both operands to 64 bits, product mod 2^64 is exact
  function automatic ex_pkg::word_t mult_model(input ex_pkg::mult_op_e op,
                                               input ex_pkg::word_t a, input ex_pkg::word_t b);
    logic [63:0] a_ext;
    logic [63:0] b_ext;
    logic [63:0] prod;
    a_ext = (op == ex_pkg::MULH || op == ex_pkg::MULHSU) ? {{32{a[31]}}, a} : {32'b0, a};
    b_ext = (op == ex_pkg::MULH) ? {{32{b[31]}}, b} : {32'b0, b};
    prod  = a_ext * b_ext;
    return (op == ex_pkg::MUL) ? prod[31:0] : prod[63:32];
  endfunction

  task automatic log_mismatch(input string msg);
    mismatch_count++;
    $display("FAILED at %0t ns: %s", $time, msg);
  endtask

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  // ALU forwarding, branch-only operators left out
  alu_fw_c: assert property (@(posedge clk) disable iff (!rst_n)
    (alu_en_i && !mult_en_i && !csr_access_i && alu_operator_i < ex_pkg::EQ)
    |-> regfile_alu_wdata_fw_o == alu_model(alu_operator_i, alu_operand_a_i, alu_operand_b_i)
  ) else log_mismatch("ALU forward data differs from model");

  fw_pass_c: assert property (@(posedge clk) disable iff (!rst_n)
    regfile_alu_we_fw_o == regfile_alu_we_i && regfile_alu_waddr_fw_o == regfile_alu_waddr_i
  ) else log_mismatch("Forward enable or address not passed through");

  branch_c: assert property (@(posedge clk) disable iff (!rst_n)
    alu_operator_i >= ex_pkg::EQ
    |-> branch_decision_o == cmp_model(alu_operator_i, alu_operand_a_i, alu_operand_b_i)
  ) else log_mismatch("Branch decision differs from model");

  jump_c: assert property (@(posedge clk) disable iff (!rst_n)
    jump_target_o == alu_operand_c_i
  ) else log_mismatch("Jump target differs from operand c");

  // Product checked in the cycle the stage accepts it
  mult_c: assert property (@(posedge clk) disable iff (!rst_n)
    (mult_en_i && !csr_access_i && ex_ready_o)
    |-> regfile_alu_wdata_fw_o == mult_model(mult_operator_i, mult_operand_a_i, mult_operand_b_i)
  ) else log_mismatch("Multiplier forward data differs from model");

  mul_no_stall_c: assert property (@(posedge clk) disable iff (!rst_n)
    (mult_en_i && mult_operator_i == ex_pkg::MUL && wb_ready_i && lsu_ready_ex_i)
    |-> ex_ready_o && !mult_multicycle_o
  ) else log_mismatch("MUL stalled the stage");

  // High word done one cycle after the split starts
  mult_second_cycle_c: assert property (@(posedge clk) disable iff (!rst_n)
    mult_multicycle_o |=> !mult_multicycle_o
  ) else log_mismatch("High product took more than two cycles");

  csr_c: assert property (@(posedge clk) disable iff (!rst_n)
    csr_access_i |-> regfile_alu_wdata_fw_o == csr_rdata_i
  ) else log_mismatch("CSR forward data differs from csr_rdata_i");

  // EX/WB register
  wb_we_c: assert property (@(posedge clk) disable iff (!rst_n)
    ex_valid_o |=> regfile_we_wb_o == $past(regfile_we_i && !lsu_err_i)
  ) else log_mismatch("Write-back enable differs from captured value");

  wb_addr_c: assert property (@(posedge clk) disable iff (!rst_n)
    (ex_valid_o && regfile_we_i && !lsu_err_i) |=> regfile_waddr_wb_o == $past(regfile_waddr_i)
  ) else log_mismatch("Write-back address differs from captured value");

  wb_clear_c: assert property (@(posedge clk) disable iff (!rst_n)
    (!ex_valid_o && wb_ready_i) |=> !regfile_we_wb_o
  ) else log_mismatch("Write-back enable not cleared");

  wb_hold_c: assert property (@(posedge clk) disable iff (!rst_n)
    (!ex_valid_o && !wb_ready_i) |=> $stable(regfile_we_wb_o)
  ) else log_mismatch("Write-back enable not held under back-pressure");

  wb_data_c: assert property (@(posedge clk) disable iff (!rst_n)
    regfile_wdata_wb_o == lsu_rdata_i
  ) else log_mismatch("Write-back data differs from lsu_rdata_i");

  // Stall control
  stall_c: assert property (@(posedge clk) disable iff (!rst_n)
    !(wb_ready_i && lsu_ready_ex_i) |-> !ex_valid_o && ex_ready_o == branch_in_ex_i
  ) else log_mismatch("Stall outputs wrong with a ready low");

  valid_c: assert property (@(posedge clk) disable iff (!rst_n)
    ((alu_en_i || mult_en_i || csr_access_i || lsu_en_i) && wb_ready_i && lsu_ready_ex_i
     && !mult_multicycle_o) |-> ex_valid_o
  ) else log_mismatch("ex_valid_o low with all units ready");

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  function automatic bit one_in(input int unsigned n);
    return $urandom_range(0, n - 1) == 0;
  endfunction

  // Corner values now and then
  function automatic ex_pkg::word_t pick_operand();
    case ($urandom_range(0, 7))
      0:       return '0;
      1:       return '1;
      2:       return 32'h8000_0000;
      3:       return 32'h7fff_ffff;
      default: return $urandom;
    endcase
  endfunction

  task automatic randomize_readies();
    wb_ready_i     = !one_in(4);
    lsu_ready_ex_i = !one_in(4);
    lsu_rdata_i    = $urandom;
  endtask

  task automatic clear_inputs();
    alu_en_i            = 1'b0;
    alu_operator_i      = ex_pkg::ADD;
    alu_operand_a_i     = '0;
    alu_operand_b_i     = '0;
    alu_operand_c_i     = '0;
    mult_en_i           = 1'b0;
    mult_operator_i     = ex_pkg::MUL;
    mult_operand_a_i    = '0;
    mult_operand_b_i    = '0;
    csr_access_i        = 1'b0;
    csr_rdata_i         = '0;
    lsu_en_i            = 1'b0;
    lsu_rdata_i         = '0;
    lsu_ready_ex_i      = 1'b1;
    lsu_err_i           = 1'b0;
    branch_in_ex_i      = 1'b0;
    regfile_alu_we_i    = 1'b0;
    regfile_alu_waddr_i = '0;
    regfile_we_i        = 1'b0;
    regfile_waddr_i     = '0;
    wb_ready_i          = 1'b1;
  endtask

  // One forward source at most, no branch beside a multiply
  task automatic issue_random_op();
    int unsigned kind;
    kind = $urandom_range(0, 3);
    randomize_readies();
    alu_operator_i      = ex_pkg::alu_op_e'($urandom_range(0, 15));
    alu_operand_a_i     = pick_operand();
    alu_operand_b_i     = one_in(4) ? alu_operand_a_i : pick_operand();
    alu_operand_c_i     = $urandom;
    mult_operator_i     = ex_pkg::mult_op_e'($urandom_range(0, 3));
    mult_operand_a_i    = pick_operand();
    mult_operand_b_i    = pick_operand();
    csr_rdata_i         = $urandom;
    alu_en_i            = (kind == 0);
    mult_en_i           = (kind == 1);
    csr_access_i        = (kind == 2);
    lsu_en_i            = (kind == 3) || one_in(4);
    lsu_err_i           = one_in(8);
    branch_in_ex_i      = (kind != 1) && one_in(4);
    regfile_alu_we_i    = one_in(2);
    regfile_alu_waddr_i = ex_pkg::reg_addr_t'($urandom);
    regfile_we_i        = lsu_en_i && !one_in(4);
    regfile_waddr_i     = ex_pkg::reg_addr_t'($urandom);
  endtask

  // Readies reshuffled each cycle, operation held until accepted
  task automatic wait_ex_ready();
    int unsigned cycles;
    cycles = 0;
    @(negedge clk);
    while (!ex_ready_o && !timed_out) begin
      if (cycles == READY_TIMEOUT) begin
        $display("Timeout: ex_ready_o stayed low for %0d cycles at %0t ns",
                 READY_TIMEOUT, $time);
        timeout_count++;
        timed_out = 1'b1;
      end else begin
        @(posedge clk);
        #DRIVE_DELAY;
        randomize_readies();
        @(negedge clk);
        cycles++;
      end
    end
    @(posedge clk);
    #DRIVE_DELAY;
  endtask

  task automatic end_run();
    $display("Mismatches: %0d, timeouts: %0d", mismatch_count, timeout_count);
    if (mismatch_count == 0 && timeout_count == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  endtask

  initial begin
    mismatch_count = 0;
    timeout_count  = 0;
    timed_out      = 1'b0;
    void'($urandom(SEED));
    clear_inputs();
    rst_n = 1'b0;
    repeat (4) @(posedge clk);
    // Reset values before release
    reset_state_c: assert (!regfile_we_wb_o && !mult_multicycle_o)
      else log_mismatch("Write-back enable or multicycle high in reset");
    #DRIVE_DELAY;
    rst_n = 1'b1;
    for (int n = 0; n < NUM_OPS && !timed_out; n++) begin
      issue_random_op();
      wait_ex_ready();
    end
    clear_inputs();
    repeat (2) @(posedge clk);
    end_run();
  end

endmodule

`default_nettype wire

// File: verilog.f
source/ex_pkg.sv
source/ex_result_if.sv
source/ex_alu.sv
source/ex_mult.sv
source/ex_wb_ctrl.sv
source/ex_stage.sv
bench/tb_ex_stage.sv

// File: Bender.yml
package:
  name: ex_stage

sources:
  - source/ex_pkg.sv
  - source/ex_result_if.sv
  - source/ex_alu.sv
  - source/ex_mult.sv
  - source/ex_wb_ctrl.sv
  - source/ex_stage.sv
  - target: test
    files:
      - bench/tb_ex_stage.sv
